//--- pmp_check.f
+incdir+hdl
hdl/pmp_pkg.sv
hdl/pmp_lzc.sv
hdl/pmp_entry.sv
hdl/pmp_cfg_regs.sv
hdl/pmp_checker.sv
hdl/pmp_top.sv
testbench/pmp_asserts.sv
testbench/pmp_monitor.sv
testbench/pmp_tb.sv

//--- Makefile
# Verilator build and run of the PMP checker testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pmp_tb
FILELIST  = pmp_check.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

# the run passes only when the log holds the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/pmp_tb.sv
/*
 * PMP checker testbench
 * directed table setups and a random phase on both handshake ports
 * answers are compared by the monitor and a watchdog bounds the run
 */
`include "pmp_defines.svh"

module pmp_tb import pmp_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_RANDOM   = 200;
    // upper bound on directed writes and checks
    localparam int NUM_DIRECTED = 80;
    localparam int NUM_TXN      = NUM_DIRECTED + 2 * NUM_RANDOM;

    logic                     clk;
    logic                     reset;
    logic                     wr_req;
    logic [`PMP_IDX_W-1:0]    wr_idx;
    logic                     wr_is_addr;
    pmp_cfg_t                 wr_cfg;
    logic [`PMP_ADDR_LEN-1:0] wr_addr;
    logic                     wr_ack;
    logic                     chk_req;
    logic [`PMP_PLEN-1:0]     chk_addr;
    pmp_access_t              chk_access;
    pmp_priv_t                chk_priv;
    logic                     chk_ack;
    logic                     chk_allow;
    logic [`PMP_IDX_W-1:0]    chk_idx;
    logic [31:0]              rng_state;
    logic [`PMP_PLEN-1:0]     probe_addr [13];
    int                       chk_issued;
    int                       err_count;
    int                       cmp_count;

    pmp_top pmp_top_inst (
        .clk_i          (clk),
        .reset_i        (reset),
        .wr_req_i       (wr_req),
        .wr_idx_i       (wr_idx),
        .wr_is_addr_i   (wr_is_addr),
        .wr_cfg_i       (wr_cfg),
        .wr_addr_i      (wr_addr),
        .wr_ack_o       (wr_ack),
        .chk_req_i      (chk_req),
        .chk_addr_i     (chk_addr),
        .chk_access_i   (chk_access),
        .chk_priv_i     (chk_priv),
        .chk_ack_o      (chk_ack),
        .chk_allow_o    (chk_allow),
        .chk_match_idx_o(chk_idx)
    );

    pmp_monitor monitor_inst (
        .clk_i       (clk),
        .reset_i     (reset),
        .wr_req_i    (wr_req),
        .wr_ack_i    (wr_ack),
        .wr_idx_i    (wr_idx),
        .wr_is_addr_i(wr_is_addr),
        .wr_cfg_i    (wr_cfg),
        .wr_addr_i   (wr_addr),
        .chk_req_i   (chk_req),
        .chk_ack_i   (chk_ack),
        .chk_addr_i  (chk_addr),
        .chk_access_i(chk_access),
        .chk_priv_i  (chk_priv),
        .chk_allow_i (chk_allow),
        .chk_idx_i   (chk_idx),
        .err_count_o (err_count),
        .cmp_count_o (cmp_count)
    );

    bind pmp_top pmp_asserts asserts_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_req_i   (wr_req_i),
        .wr_ack_i   (wr_ack_o),
        .chk_req_i  (chk_req_i),
        .chk_ack_i  (chk_ack_o),
        .chk_allow_i(chk_allow_o),
        .chk_idx_i  (chk_match_idx_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 32-bit xorshift step on the shared state
    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic pmp_cfg_t make_cfg(input logic lock, input pmp_addr_mode_t mode,
                                          input logic [2:0] xwr);
        pmp_cfg_t c;
        c           = '0;
        c.locked    = lock;
        c.addr_mode = mode;
        {c.x, c.w, c.r} = xwr;
        return c;
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    // one full four-phase write of a cfg byte or an address register
    task automatic write_entry(input logic [`PMP_IDX_W-1:0] idx, input logic is_addr,
                               input pmp_cfg_t cfg, input logic [`PMP_ADDR_LEN-1:0] a);
        @(negedge clk);
        wr_req     = 1'b1;
        wr_idx     = idx;
        wr_is_addr = is_addr;
        wr_cfg     = cfg;
        wr_addr    = a;
        do @(negedge clk); while (!wr_ack);
        wr_req = 1'b0;
        do @(negedge clk); while (wr_ack);
    endtask

    task automatic run_check(input logic [`PMP_PLEN-1:0] a, input pmp_access_t acc,
                             input pmp_priv_t priv);
        @(negedge clk);
        chk_req    = 1'b1;
        chk_addr   = a;
        chk_access = acc;
        chk_priv   = priv;
        chk_issued++;
        do @(negedge clk); while (!chk_ack);
        // req stays up one more cycle so ack and the answer must hold
        @(negedge clk);
        chk_req = 1'b0;
        do @(negedge clk); while (chk_ack);
    endtask

    // watchdog allows eight periods per transaction plus slack for resets
    initial begin
        #(NUM_TXN * 8 * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("timeout: a handshake did not complete within the expected run time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rng_state  = 32'd48;
        chk_issued = 0;
        reset      = 1'b1;
        wr_req     = 1'b0;
        wr_idx     = '0;
        wr_is_addr = 1'b0;
        wr_cfg     = '0;
        wr_addr    = '0;
        chk_req    = 1'b0;
        chk_addr   = '0;
        chk_access = ACC_READ;
        chk_priv   = PRIV_M;
        probe_addr = '{34'h3ffc, 34'h4000, 34'h4003, 34'h4004, 34'h7ffc, 34'h8000, 34'h801f,
                       34'h8020, 34'hf_fffc, 34'h10_0000, 34'h10_7fff, 34'h10_8000,
                       34'h3_ffff_fffc};
        apply_reset();

        // only the default rule applies to an empty table
        for (int i = 0; i < 6; i++) begin
            run_check(34'h0_1234_5678 * 34'(i + 1), pmp_access_t'(2'(i % 3)), pmp_priv_t'(i[0]));
        end

        // entry 0 stays OFF and only bounds the TOR range [0x400, 0x800) of entry 1
        write_entry(4'd0, 1'b1, '0, 32'h100);
        write_entry(4'd1, 1'b1, '0, 32'h200);
        write_entry(4'd1, 1'b0, make_cfg(1'b0, TOR, 3'b001), '0);
        run_check(34'h3fc, ACC_READ, PRIV_U);
        run_check(34'h400, ACC_READ, PRIV_U);
        run_check(34'h400, ACC_WRITE, PRIV_U);
        run_check(34'h7fc, ACC_READ, PRIV_U);
        run_check(34'h7fc, ACC_EXEC, PRIV_U);
        run_check(34'h800, ACC_READ, PRIV_U);
        run_check(34'h600, ACC_WRITE, PRIV_M);

        // NA4 at 0x4000, NAPOT 32 bytes at 0x8000 and 32 KiB at 0x100000
        write_entry(4'd2, 1'b1, '0, 32'h1000);
        write_entry(4'd2, 1'b0, make_cfg(1'b0, NA4, 3'b100), '0);
        write_entry(4'd3, 1'b1, '0, 32'h2003);
        write_entry(4'd3, 1'b0, make_cfg(1'b0, NAPOT, 3'b011), '0);
        write_entry(4'd4, 1'b1, '0, 32'h4_0fff);
        write_entry(4'd4, 1'b0, make_cfg(1'b0, NAPOT, 3'b110), '0);
        // all ones register catches everything the others miss
        write_entry(4'd7, 1'b1, '0, 32'hffff_ffff);
        write_entry(4'd7, 1'b0, make_cfg(1'b0, NAPOT, 3'b001), '0);
        foreach (probe_addr[i]) begin
            run_check(probe_addr[i], ACC_EXEC, PRIV_U);
            run_check(probe_addr[i], ACC_WRITE, PRIV_U);
        end

        // entry 5 overlaps entry 3 with full rights but entry 3 still wins
        write_entry(4'd5, 1'b1, '0, 32'h2003);
        write_entry(4'd5, 1'b0, make_cfg(1'b0, NAPOT, 3'b111), '0);
        run_check(34'h8010, ACC_WRITE, PRIV_U);
        run_check(34'h8010, ACC_EXEC, PRIV_U);
        run_check(34'h3f0, ACC_READ, PRIV_U);

        // locked TOR binds machine mode and later writes to it and below are dropped
        write_entry(4'd1, 1'b0, make_cfg(1'b1, TOR, 3'b001), '0);
        write_entry(4'd1, 1'b0, make_cfg(1'b0, NAPOT, 3'b111), '0);
        write_entry(4'd1, 1'b1, '0, 32'h300);
        write_entry(4'd0, 1'b1, '0, 32'h180);
        write_entry(4'd2, 1'b1, '0, 32'h1001);
        run_check(34'h3fc, ACC_WRITE, PRIV_M);
        run_check(34'h400, ACC_WRITE, PRIV_M);
        run_check(34'h400, ACC_READ, PRIV_M);
        run_check(34'h7fc, ACC_EXEC, PRIV_M);
        run_check(34'h800, ACC_WRITE, PRIV_M);
        run_check(34'h4004, ACC_EXEC, PRIV_U);

        // random tables and checks with a write and a check in flight together
        apply_reset();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            logic [31:0]              r1;
            logic [31:0]              r2;
            logic [31:0]              r3;
            logic [`PMP_ADDR_LEN-1:0] wa;
            pmp_cfg_t                 wc;
            logic [`PMP_PLEN-1:0]     ca;
            r1 = xorshift32();
            r2 = xorshift32();
            r3 = xorshift32();
            // small registers so checks hit and now and then all ones
            wa = (r1[31:28] == 4'h0) ? '1 : {20'h0, r1[11:0]};
            // lock set in one write out of eight with random reserved bits
            wc = pmp_cfg_t'({r2[15:13] == 3'd0, r2[6:0]});
            ca = (r3[31:29] == 3'd0) ? {r3, r2[17:16]} : {20'h0, r3[13:0]};
            fork
                write_entry(4'(r1[14:12]), r1[15], wc, wa);
                run_check(ca, pmp_access_t'(2'(r3[27:16] % 12'd3)), pmp_priv_t'(r3[28]));
            join
        end

        repeat (4) @(negedge clk);
        if (cmp_count != chk_issued) begin
            $display("monitor compared a different number of answers than checks issued");
        end
        $display("checks issued %0d, compared %0d, errors %0d", chk_issued, cmp_count, err_count);
        if (err_count == 0 && cmp_count == chk_issued) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- testbench/pmp_monitor.sv
/*
 * PMP check monitor
 * keeps a shadow of the entry table, predicts every check answer
 * from the address range rules and compares it with the DUT
 */
`include "pmp_defines.svh"

module pmp_monitor import pmp_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     wr_req_i,
    input  logic                     wr_ack_i,
    input  logic [`PMP_IDX_W-1:0]    wr_idx_i,
    input  logic                     wr_is_addr_i,
    input  pmp_cfg_t                 wr_cfg_i,
    input  logic [`PMP_ADDR_LEN-1:0] wr_addr_i,
    input  logic                     chk_req_i,
    input  logic                     chk_ack_i,
    input  logic [`PMP_PLEN-1:0]     chk_addr_i,
    input  pmp_access_t              chk_access_i,
    input  pmp_priv_t                chk_priv_i,
    input  logic                     chk_allow_i,
    input  logic [`PMP_IDX_W-1:0]    chk_idx_i,
    output int                       err_count_o,
    output int                       cmp_count_o
);

    localparam int NUM = `PMP_NUM_ENTRIES;

    pmp_cfg_t                 shadow_cfg  [NUM];
    logic [`PMP_ADDR_LEN-1:0] shadow_addr [NUM];
    logic                     exp_allow;
    logic [`PMP_IDX_W-1:0]    exp_idx;
    logic [`PMP_PLEN-1:0]     exp_addr;
    logic                     ack_seen  = 1'b0;
    int                       err_count = 0;
    int                       cmp_count = 0;

    // byte range of one entry, upper bound exclusive
    function automatic logic in_region(input pmp_addr_mode_t mode,
                                       input logic [`PMP_ADDR_LEN-1:0] cur,
                                       input logic [`PMP_ADDR_LEN-1:0] prev,
                                       input logic [`PMP_PLEN-1:0] a);
        longint unsigned lo;
        longint unsigned hi;
        int              k;
        lo = 0;
        hi = 0;
        k  = 0;
        // trailing ones of the register
        for (int i = 0; i < `PMP_ADDR_LEN; i++) begin
            if (cur[i] && k == i) begin
                k++;
            end
        end
        case (mode)
            TOR: begin
                lo = 64'(prev) << 2;
                hi = 64'(cur) << 2;
            end
            NA4: begin
                lo = 64'(cur) << 2;
                hi = lo + 64'd4;
            end
            NAPOT: begin
                if (k == `PMP_ADDR_LEN) begin
                    hi = 64'd1 << `PMP_PLEN;
                end else begin
                    // 2^(k+3) bytes, base aligned to that size
                    lo = ((64'(cur) << 2) >> (k + 3)) << (k + 3);
                    hi = lo + (64'd1 << (k + 3));
                end
            end
            default: return 1'b0;
        endcase
        return (64'(a) >= lo) && (64'(a) < hi);
    endfunction

    // expected allow and winning index for one access
    function automatic logic pmp_ref_check(input logic [`PMP_PLEN-1:0] a,
                                           input pmp_access_t acc,
                                           input pmp_priv_t priv,
                                           output logic [`PMP_IDX_W-1:0] idx);
        logic                     allow;
        logic                     found;
        logic [`PMP_ADDR_LEN-1:0] prev;
        pmp_cfg_t                 c;
        // no match: machine passes, user is refused
        allow = (priv == PRIV_M);
        idx   = `PMP_IDX_NONE;
        found = 1'b0;
        prev  = '0;
        for (int i = 0; i < NUM; i++) begin
            c = shadow_cfg[i];
            if (!found && in_region(c.addr_mode, shadow_addr[i], prev, a)) begin
                found = 1'b1;
                idx   = `PMP_IDX_W'(i);
                if (!c.locked && priv == PRIV_M) begin
                    allow = 1'b1;
                end else begin
                    allow = (acc == ACC_READ && c.r) || (acc == ACC_WRITE && c.w)
                            || (acc == ACC_EXEC && c.x);
                end
            end
            prev = shadow_addr[i];
        end
        return allow;
    endfunction

    // own lock, or a locked TOR entry right above for address writes
    function automatic logic write_blocked(input int idx, input logic is_addr);
        if (shadow_cfg[idx].locked) begin
            return 1'b1;
        end
        if (is_addr && idx + 1 < NUM) begin
            return shadow_cfg[idx + 1].locked && shadow_cfg[idx + 1].addr_mode == TOR;
        end
        return 1'b0;
    endfunction

    always @(posedge clk_i) begin
        int widx;
        widx = int'(wr_idx_i);
        if (reset_i) begin
            for (int i = 0; i < NUM; i++) begin
                shadow_cfg[i]  = '0;
                shadow_addr[i] = '0;
            end
        end else begin
            // prediction uses the table before this edge's write
            if (chk_req_i && !chk_ack_i) begin
                exp_addr  = chk_addr_i;
                exp_allow = pmp_ref_check(chk_addr_i, chk_access_i, chk_priv_i, exp_idx);
            end
            if (wr_req_i && !wr_ack_i && widx < NUM && !write_blocked(widx, wr_is_addr_i)) begin
                if (wr_is_addr_i) begin
                    shadow_addr[widx] = wr_addr_i;
                end else begin
                    shadow_cfg[widx]          = wr_cfg_i;
                    shadow_cfg[widx].reserved = 2'b00;
                end
            end
        end
    end

    // compare once per answer, on the first low clock phase with ack up
    always @(negedge clk_i) begin
        if (chk_ack_i && !ack_seen) begin
            cmp_count++;
            if (chk_allow_i !== exp_allow || chk_idx_i !== exp_idx) begin
                err_count++;
                $display("CHECK FAILED at %0t: addr %h allow %b idx %0d, expected allow %b idx %0d",
                         $time, exp_addr, chk_allow_i, chk_idx_i, exp_allow, exp_idx);
            end
        end
        ack_seen = chk_ack_i;
    end

    assign err_count_o = err_count;
    assign cmp_count_o = cmp_count;

endmodule

//--- testbench/pmp_asserts.sv
/*
 * Handshake assertions for the PMP top level
 * bound onto pmp_top, covers the four-phase write and check ports
 */
`include "pmp_defines.svh"

module pmp_asserts (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  wr_req_i,
    input logic                  wr_ack_i,
    input logic                  chk_req_i,
    input logic                  chk_ack_i,
    input logic                  chk_allow_i,
    input logic [`PMP_IDX_W-1:0] chk_idx_i
);

    // req may only fall once the slave has acked
    assert property (@(posedge clk_i) disable iff (reset_i) $fell(wr_req_i) |-> wr_ack_i)
        else $error("write req dropped before ack");
    assert property (@(posedge clk_i) disable iff (reset_i) $fell(chk_req_i) |-> chk_ack_i)
        else $error("check req dropped before ack");

    // ack only answers a pending req
    assert property (@(posedge clk_i) disable iff (reset_i) $rose(wr_ack_i) |-> $past(wr_req_i))
        else $error("write ack rose without req");
    assert property (@(posedge clk_i) disable iff (reset_i) $rose(chk_ack_i) |-> $past(chk_req_i))
        else $error("check ack rose without req");

    // answer holds for the whole ack phase
    assert property (@(posedge clk_i) disable iff (reset_i)
        chk_ack_i && $past(chk_ack_i) |-> $stable(chk_allow_i) && $stable(chk_idx_i))
        else $error("check result changed while ack high");

    // first edge out of reset sees both acks idle
    assert property (@(posedge clk_i) $fell(reset_i) |-> !wr_ack_i && !chk_ack_i)
        else $error("ack high right after reset");

endmodule

//--- hdl/pmp_top.sv
/*
 * PMP checker top level
 * entry table with its write port feeding the access checker
 */
`include "pmp_defines.svh"

module pmp_top import pmp_pkg::*; (
    input  logic                     clk_i,
    input  logic                     reset_i,
    // table write port
    input  logic                     wr_req_i,
    input  logic [`PMP_IDX_W-1:0]    wr_idx_i,
    input  logic                     wr_is_addr_i,
    input  pmp_cfg_t                 wr_cfg_i,
    input  logic [`PMP_ADDR_LEN-1:0] wr_addr_i,
    output logic                     wr_ack_o,
    // access check port
    input  logic                     chk_req_i,
    input  logic [`PMP_PLEN-1:0]     chk_addr_i,
    input  pmp_access_t              chk_access_i,
    input  pmp_priv_t                chk_priv_i,
    output logic                     chk_ack_o,
    output logic                     chk_allow_o,
    output logic [`PMP_IDX_W-1:0]    chk_match_idx_o
);

    logic [`PMP_NUM_ENTRIES*8-1:0]             cfg_flat;
    logic [`PMP_NUM_ENTRIES*`PMP_ADDR_LEN-1:0] addr_flat;

    pmp_cfg_regs cfg_regs_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wr_req_i    (wr_req_i),
        .wr_idx_i    (wr_idx_i),
        .wr_is_addr_i(wr_is_addr_i),
        .wr_cfg_i    (wr_cfg_i),
        .wr_addr_i   (wr_addr_i),
        .wr_ack_o    (wr_ack_o),
        .cfg_o       (cfg_flat),
        .addr_o      (addr_flat)
    );

    pmp_checker checker_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cfg_i          (cfg_flat),
        .addr_i         (addr_flat),
        .chk_req_i      (chk_req_i),
        .chk_addr_i     (chk_addr_i),
        .chk_access_i   (chk_access_i),
        .chk_priv_i     (chk_priv_i),
        .chk_ack_o      (chk_ack_o),
        .chk_allow_o    (chk_allow_o),
        .chk_match_idx_o(chk_match_idx_o)
    );

endmodule

//--- hdl/pmp_checker.sv
/*
 * PMP access checker
 * matches an address against all entries in parallel, lets the
 * lowest matching entry decide and answers over a four-phase
 * handshake one cycle after the request is sampled
 */
`include "pmp_defines.svh"

module pmp_checker import pmp_pkg::*; (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  logic [`PMP_NUM_ENTRIES*8-1:0]             cfg_i,
    input  logic [`PMP_NUM_ENTRIES*`PMP_ADDR_LEN-1:0] addr_i,
    input  logic                                      chk_req_i,
    input  logic [`PMP_PLEN-1:0]                      chk_addr_i,
    input  pmp_access_t                               chk_access_i,
    input  pmp_priv_t                                 chk_priv_i,
    output logic                                      chk_ack_o,
    output logic                                      chk_allow_o,
    output logic [`PMP_IDX_W-1:0]                     chk_match_idx_o
);

    localparam int NUM = `PMP_NUM_ENTRIES;
    localparam int IW  = `PMP_IDX_W;

    pmp_cfg_t                 cfg   [NUM];
    logic [`PMP_ADDR_LEN-1:0] addr  [NUM];
    logic [NUM-1:0]           match;
    logic                     hit;
    pmp_cfg_t                 hit_cfg;
    logic [IW-1:0]            hit_idx;
    logic                     allow;
    logic                     chk_ack_q;
    logic                     chk_allow_q;
    logic [IW-1:0]            chk_idx_q;

    for (genvar g = 0; g < NUM; g++) begin : g_entry
        assign cfg[g]  = pmp_cfg_t'(cfg_i[g*8 +: 8]);
        assign addr[g] = addr_i[g*`PMP_ADDR_LEN +: `PMP_ADDR_LEN];

        // entry 0 uses address zero as its TOR lower bound
        pmp_entry entry_inst (
            .addr_i          (chk_addr_i),
            .conf_addr_i     (addr[g]),
            .conf_addr_prev_i((g == 0) ? '0 : addr[(g == 0) ? 0 : g - 1]),
            .conf_addr_mode_i(cfg[g].addr_mode),
            .match_o         (match[g])
        );
    end

    // static priority, lowest index is kept last
    always_comb begin
        hit     = 1'b0;
        hit_cfg = '0;
        hit_idx = `PMP_IDX_NONE;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_cfg = cfg[i];
                hit_idx = IW'(i);
            end
        end
    end

    always_comb begin
        if (!hit) begin
            // default rule, only machine mode passes
            allow = (chk_priv_i == PRIV_M);
        end else if (!hit_cfg.locked && chk_priv_i == PRIV_M) begin
            allow = 1'b1;
        end else begin
            case (chk_access_i)
                ACC_READ:  allow = hit_cfg.r;
                ACC_WRITE: allow = hit_cfg.w;
                ACC_EXEC:  allow = hit_cfg.x;
                default:   allow = 1'b0;
            endcase
        end
    end

    // results only load on a fresh request, so they hold while ack is high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            chk_ack_q   <= 1'b0;
            chk_allow_q <= 1'b0;
        end else if (chk_req_i && !chk_ack_q) begin
            chk_ack_q   <= 1'b1;
            chk_allow_q <= allow;
        end else if (!chk_req_i) begin
            chk_ack_q <= 1'b0;
        end
    end

    // index is payload and only loads with a new answer
    always_ff @(posedge clk_i) begin
        if (chk_req_i && !chk_ack_q) begin
            chk_idx_q <= hit_idx;
        end
    end

    assign chk_ack_o       = chk_ack_q;
    assign chk_allow_o     = chk_allow_q;
    assign chk_match_idx_o = chk_idx_q;

endmodule

//--- hdl/pmp_cfg_regs.sv
/*
 * PMP entry table
 * holds the cfg bytes and address registers, runs the four-phase
 * write handshake and drops writes blocked by lock bits
 */
`include "pmp_defines.svh"

module pmp_cfg_regs import pmp_pkg::*; (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic                                          wr_req_i,
    input  logic [`PMP_IDX_W-1:0]                         wr_idx_i,
    input  logic                                          wr_is_addr_i,
    input  pmp_cfg_t                                      wr_cfg_i,
    input  logic [`PMP_ADDR_LEN-1:0]                      wr_addr_i,
    output logic                                          wr_ack_o,
    output logic [`PMP_NUM_ENTRIES*8-1:0]                 cfg_o,
    output logic [`PMP_NUM_ENTRIES*`PMP_ADDR_LEN-1:0]     addr_o
);

    localparam int NUM = `PMP_NUM_ENTRIES;
    localparam int IW  = `PMP_IDX_W;

    pmp_cfg_t                 cfg_q  [NUM];
    logic [`PMP_ADDR_LEN-1:0] addr_q [NUM];
    logic                     wr_ack_q;
    logic                     own_locked;
    logic                     next_tor_locked;
    pmp_cfg_t                 cfg_clean;

    // reserved bits always read back as zero
    always_comb begin
        cfg_clean          = wr_cfg_i;
        cfg_clean.reserved = 2'b00;
    end

    // lock state of the addressed entry and of the one above it
    always_comb begin
        own_locked      = 1'b0;
        next_tor_locked = 1'b0;
        for (int i = 0; i < NUM; i++) begin
            if (wr_idx_i == IW'(i)) begin
                own_locked = cfg_q[i].locked;
            end
        end
        // a locked TOR entry also freezes the address register below it
        for (int i = 1; i < NUM; i++) begin
            if (wr_idx_i == IW'(i - 1)) begin
                next_tor_locked = cfg_q[i].locked && (cfg_q[i].addr_mode == TOR);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ack_q <= 1'b0;
            for (int i = 0; i < NUM; i++) begin
                cfg_q[i]  <= '0;
                addr_q[i] <= '0;
            end
        end else if (wr_req_i && !wr_ack_q) begin
            // new request, write and ack in the same edge
            wr_ack_q <= 1'b1;
            for (int i = 0; i < NUM; i++) begin
                if (wr_idx_i == IW'(i) && !own_locked) begin
                    if (!wr_is_addr_i) begin
                        cfg_q[i] <= cfg_clean;
                    end else if (!next_tor_locked) begin
                        addr_q[i] <= wr_addr_i;
                    end
                end
            end
        end else if (!wr_req_i) begin
            wr_ack_q <= 1'b0;
        end
    end

    assign wr_ack_o = wr_ack_q;

    // flatten the table towards the checker
    for (genvar g = 0; g < NUM; g++) begin : g_flat
        assign cfg_o[g*8 +: 8]                             = cfg_q[g];
        assign addr_o[g*`PMP_ADDR_LEN +: `PMP_ADDR_LEN]    = addr_q[g];
    end

endmodule

//--- hdl/pmp_entry.sv
/*
 * Single PMP entry address match
 * compares a physical address against one entry in TOR, NA4
 * or NAPOT mode; OFF never matches. purely combinational
 */
`include "pmp_defines.svh"

module pmp_entry import pmp_pkg::*; (
    input  logic [`PMP_PLEN-1:0]     addr_i,
    input  logic [`PMP_ADDR_LEN-1:0] conf_addr_i,
    input  logic [`PMP_ADDR_LEN-1:0] conf_addr_prev_i,
    input  pmp_addr_mode_t           conf_addr_mode_i,
    output logic                     match_o
);

    localparam int PLEN = `PMP_PLEN;
    localparam int SW   = $clog2(PLEN) + 1;

    logic [`PMP_ADDR_LEN-1:0]         conf_addr_n;
    logic [$clog2(`PMP_ADDR_LEN)-1:0] trail_ones;
    logic                             all_ones;
    logic [PLEN-1:0]                  top_addr;
    logic [PLEN-1:0]                  bot_addr;
    logic [SW-1:0]                    size;
    logic [PLEN-1:0]                  mask;
    logic [PLEN-1:0]                  base;

    // trailing ones of the register are trailing zeros of its inverse
    assign conf_addr_n = ~conf_addr_i;

    pmp_lzc #(
        .WIDTH(`PMP_ADDR_LEN)
    ) lzc_inst (
        .in_i   (conf_addr_n),
        .cnt_o  (trail_ones),
        .empty_o(all_ones)
    );

    // byte addresses of this and the previous register
    assign top_addr = {conf_addr_i, 2'b00};
    assign bot_addr = {conf_addr_prev_i, 2'b00};

    // region is 2^size bytes, 4 bytes for NA4
    assign size = (conf_addr_mode_i == NA4) ? SW'(2) : SW'(trail_ones) + SW'(3);
    // size of PLEN or more shifts the mask out entirely
    assign mask = {PLEN{1'b1}} << size;
    assign base = top_addr & mask;

    always_comb begin
        case (conf_addr_mode_i)
            TOR:     match_o = (addr_i >= bot_addr) && (addr_i < top_addr);
            NA4:     match_o = (addr_i & mask) == base;
            // register of all ones covers the whole space
            NAPOT:   match_o = all_ones || ((addr_i & mask) == base);
            default: match_o = 1'b0;
        endcase
    end

endmodule

//--- hdl/pmp_lzc.sv
/*
 * Trailing zero counter
 * priority search from bit 0; the entry feeds it an inverted
 * address register so the result is the count of trailing ones
 */
module pmp_lzc #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    localparam int CW = $clog2(WIDTH);

    // all zeros input, count saturates at WIDTH-1
    assign empty_o = ~|in_i;

    always_comb begin
        cnt_o = CW'(WIDTH - 1);
        // scan from the top so the lowest set bit is the last one kept
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (in_i[i]) begin
                cnt_o = CW'(i);
            end
        end
    end

endmodule

//--- hdl/pmp_pkg.sv
/*
 * PMP checker types
 * address matching modes, access kinds, privilege levels
 * and the per-entry configuration byte
 */
package pmp_pkg;

    // address matching mode, encoding as in the A field of pmpcfg
    typedef enum logic [1:0] {
        OFF   = 2'd0,
        TOR   = 2'd1,
        NA4   = 2'd2,
        NAPOT = 2'd3
    } pmp_addr_mode_t;

    // kind of access being checked
    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } pmp_access_t;

    typedef enum logic {
        PRIV_U = 1'b0,
        PRIV_M = 1'b1
    } pmp_priv_t;

    // one pmpcfg byte, msb first: L, reserved, A, X, W, R
    typedef struct packed {
        logic           locked;
        logic [1:0]     reserved;
        pmp_addr_mode_t addr_mode;
        logic           x;
        logic           w;
        logic           r;
    } pmp_cfg_t;

endpackage

//--- hdl/pmp_defines.svh
/*
 * PMP checker global sizes
 * physical address width, address register width,
 * table depth and entry index coding
 */
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// physical address width in bits
`define PMP_PLEN 34
// address register holds the physical address shifted right by 2
`define PMP_ADDR_LEN 32
`define PMP_NUM_ENTRIES 8
// index width leaves room for the reserved no-match code
`define PMP_IDX_W 4
`define PMP_IDX_NONE 4'hf

`endif
